// File: src/tlb_pkg.sv
// Shared definitions for the two-channel address translation buffer
//  - default table size and address widths
//  - fixed page offset width
//  - configuration opcode and handshake state encodings

package tlb_pkg;

  // Default number of mapping entries
  localparam int unsigned TLB_NUM_ENTRIES = 8;

  // Default address widths
  localparam int unsigned TLB_VADDR_W = 32;
  localparam int unsigned TLB_PADDR_W = 34;

  // 4 KiB pages, fixed for the whole design
  localparam int unsigned TLB_PAGE_W = 12;

  // Configuration port opcodes
  typedef enum logic [1:0] {
    CFG_NOP   = 2'b00,
    CFG_WRITE = 2'b01,
    CFG_INVAL = 2'b10,
    CFG_FLUSH = 2'b11
  } cfg_op_e;

  // Handshake state shared by the lookup channels and the merge
  typedef enum logic [1:0] {
    // Waiting for a request
    HS_IDLE  = 2'b00,
    // Table result in use
    HS_CHECK = 2'b01,
    // Waiting for downstream
    HS_BUSY  = 2'b10,
    // Ack raised, waiting for req to drop
    HS_DONE  = 2'b11
  } hs_state_e;

endpackage

// File: src/tlb_entry_table.sv
// Fully associative page mapping table
//  - valid, vpn and ppn per entry
//  - four-phase configuration port with NOP, WRITE, INVAL and FLUSH
//  - two parallel combinational lookups, lowest matching index wins

`timescale 1ns/100ps

module tlb_entry_table #(
  parameter int unsigned NUM_ENTRIES = tlb_pkg::TLB_NUM_ENTRIES,
  parameter int unsigned VADDR_W     = tlb_pkg::TLB_VADDR_W,
  parameter int unsigned PADDR_W     = tlb_pkg::TLB_PADDR_W
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  cfg_req_i,
  input  tlb_pkg::cfg_op_e                      cfg_op_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0]        cfg_idx_i,
  input  logic [VADDR_W-tlb_pkg::TLB_PAGE_W-1:0] cfg_vpn_i,
  input  logic [PADDR_W-tlb_pkg::TLB_PAGE_W-1:0] cfg_ppn_i,
  output logic                                  cfg_ack_o,
  input  logic [VADDR_W-tlb_pkg::TLB_PAGE_W-1:0] wr_vpn_i,
  output logic                                  wr_hit_o,
  output logic [PADDR_W-tlb_pkg::TLB_PAGE_W-1:0] wr_ppn_o,
  input  logic [VADDR_W-tlb_pkg::TLB_PAGE_W-1:0] rd_vpn_i,
  output logic                                  rd_hit_o,
  output logic [PADDR_W-tlb_pkg::TLB_PAGE_W-1:0] rd_ppn_o
);

  import tlb_pkg::*;

  localparam int unsigned VPN_W = VADDR_W - TLB_PAGE_W;
  localparam int unsigned PPN_W = PADDR_W - TLB_PAGE_W;

  logic [NUM_ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]       vpn_q [NUM_ENTRIES];
  logic [PPN_W-1:0]       ppn_q [NUM_ENTRIES];
  logic                   cfg_ack_q;
  logic                   cfg_start;

  // A new command is taken only while the previous ack is low
  assign cfg_start = cfg_req_i & ~cfg_ack_q;
  assign cfg_ack_o = cfg_ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q   <= '0;
      cfg_ack_q <= 1'b0;
    end else begin
      if (cfg_start) begin
        cfg_ack_q <= 1'b1;
        case (cfg_op_i)
          CFG_WRITE: valid_q[cfg_idx_i] <= 1'b1;
          CFG_INVAL: valid_q[cfg_idx_i] <= 1'b0;
          CFG_FLUSH: valid_q <= '0;
          default: ;
        endcase
      end else if (!cfg_req_i) begin
        cfg_ack_q <= 1'b0;
      end
    end
  end

  // Mapping payload
  always_ff @(posedge clk_i) begin
    if (cfg_start && cfg_op_i == CFG_WRITE) begin
      vpn_q[cfg_idx_i] <= cfg_vpn_i;
      ppn_q[cfg_idx_i] <= cfg_ppn_i;
    end
  end

  // Scan from the top so the lowest matching index is kept last
  always_comb begin
    wr_hit_o = 1'b0;
    wr_ppn_o = '0;
    rd_hit_o = 1'b0;
    rd_ppn_o = '0;
    for (int i = int'(NUM_ENTRIES) - 1; i >= 0; i--) begin
      if (valid_q[i] && vpn_q[i] == wr_vpn_i) begin
        wr_hit_o = 1'b1;
        wr_ppn_o = ppn_q[i];
      end
      if (valid_q[i] && vpn_q[i] == rd_vpn_i) begin
        rd_hit_o = 1'b1;
        rd_ppn_o = ppn_q[i];
      end
    end
  end

endmodule

// File: src/tlb_lookup_chan.sv
// One requester channel of the translation buffer
//  - registers the virtual address on a four-phase request
//  - checks the table, answers misses with an error
//  - forwards hits to the merge and acks once downstream is done

`timescale 1ns/100ps

module tlb_lookup_chan #(
  parameter int unsigned VADDR_W = tlb_pkg::TLB_VADDR_W,
  parameter int unsigned PADDR_W = tlb_pkg::TLB_PADDR_W
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Requester side
  input  logic                                   req_i,
  input  logic [VADDR_W-1:0]                     vaddr_i,
  output logic                                   ack_o,
  output logic                                   err_o,
  // Table lookup
  output logic [VADDR_W-tlb_pkg::TLB_PAGE_W-1:0] tbl_vpn_o,
  input  logic                                   tbl_hit_i,
  input  logic [PADDR_W-tlb_pkg::TLB_PAGE_W-1:0] tbl_ppn_i,
  // Towards the merge
  output logic                                   xl_req_o,
  output logic [PADDR_W-1:0]                     xl_paddr_o,
  input  logic                                   xl_ack_i
);

  import tlb_pkg::*;

  hs_state_e            state_q;
  logic                 ack_q;
  logic                 err_q;
  logic                 xl_req_q;
  logic [VADDR_W-1:0]   vaddr_q;
  logic [PADDR_W-1:0]   paddr_q;

  // Table sees the registered page number while in HS_CHECK
  assign tbl_vpn_o  = vaddr_q[VADDR_W-1:TLB_PAGE_W];
  assign ack_o      = ack_q;
  assign err_o      = err_q;
  assign xl_req_o   = xl_req_q;
  assign xl_paddr_o = paddr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= HS_IDLE;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      xl_req_q <= 1'b0;
    end else begin
      case (state_q)
        HS_IDLE: begin
          if (req_i) begin
            state_q <= HS_CHECK;
          end
        end
        HS_CHECK: begin
          if (tbl_hit_i) begin
            xl_req_q <= 1'b1;
            state_q  <= HS_BUSY;
          end else begin
            // Miss is answered here, nothing goes downstream
            ack_q   <= 1'b1;
            err_q   <= 1'b1;
            state_q <= HS_DONE;
          end
        end
        HS_BUSY: begin
          if (xl_ack_i) begin
            xl_req_q <= 1'b0;
            ack_q    <= 1'b1;
            err_q    <= 1'b0;
            state_q  <= HS_DONE;
          end
        end
        HS_DONE: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= HS_IDLE;
          end
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  // Address payload
  always_ff @(posedge clk_i) begin
    if (state_q == HS_IDLE && req_i) begin
      vaddr_q <= vaddr_i;
    end
    if (state_q == HS_CHECK && tbl_hit_i) begin
      paddr_q <= {tbl_ppn_i, vaddr_q[TLB_PAGE_W-1:0]};
    end
  end

endmodule

// File: src/tlb_xlat_merge.sv
// Merge of translated hits from both channels
//  - round-robin pick between write and read requests
//  - one downstream transaction at a time over four-phase req/ack
//  - write flag follows the granted source

`timescale 1ns/100ps

module tlb_xlat_merge #(
  parameter int unsigned PADDR_W = tlb_pkg::TLB_PADDR_W
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Write channel
  input  logic               wr_req_i,
  input  logic [PADDR_W-1:0] wr_paddr_i,
  output logic               wr_ack_o,
  // Read channel
  input  logic               rd_req_i,
  input  logic [PADDR_W-1:0] rd_paddr_i,
  output logic               rd_ack_o,
  // Downstream memory port
  output logic               mst_req_o,
  output logic [PADDR_W-1:0] mst_paddr_o,
  output logic               mst_we_o,
  input  logic               mst_ack_i
);

  import tlb_pkg::*;

  hs_state_e          state_q;
  logic               rr_rd_q;
  logic               grant_rd_q;
  logic               mst_req_q;
  logic               xl_ack_q;
  logic [PADDR_W-1:0] mst_paddr_q;
  logic               sel_rd;
  logic               granted_req;

  // Contested requests go to the side the pointer favours
  assign sel_rd      = (wr_req_i && rd_req_i) ? rr_rd_q : rd_req_i;
  assign granted_req = grant_rd_q ? rd_req_i : wr_req_i;

  assign mst_req_o   = mst_req_q;
  assign mst_paddr_o = mst_paddr_q;
  assign mst_we_o    = ~grant_rd_q;
  assign wr_ack_o    = xl_ack_q & ~grant_rd_q;
  assign rd_ack_o    = xl_ack_q & grant_rd_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= HS_IDLE;
      rr_rd_q    <= 1'b0;
      grant_rd_q <= 1'b0;
      mst_req_q  <= 1'b0;
      xl_ack_q   <= 1'b0;
    end else begin
      case (state_q)
        HS_IDLE: begin
          // Previous downstream ack must be gone first
          if ((wr_req_i || rd_req_i) && !mst_ack_i) begin
            grant_rd_q <= sel_rd;
            rr_rd_q    <= ~sel_rd;
            mst_req_q  <= 1'b1;
            state_q    <= HS_BUSY;
          end
        end
        HS_BUSY: begin
          if (mst_ack_i) begin
            mst_req_q <= 1'b0;
            xl_ack_q  <= 1'b1;
            state_q   <= HS_DONE;
          end
        end
        HS_DONE: begin
          if (!granted_req) begin
            xl_ack_q <= 1'b0;
            state_q  <= HS_IDLE;
          end
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  // Downstream address held for the whole request
  always_ff @(posedge clk_i) begin
    if (state_q == HS_IDLE && (wr_req_i || rd_req_i) && !mst_ack_i) begin
      mst_paddr_q <= sel_rd ? rd_paddr_i : wr_paddr_i;
    end
  end

endmodule

// File: src/tlb_xlat_top.sv
// Top level of the two-channel address translation buffer
//  - shared mapping table with its configuration port
//  - write and read lookup channels
//  - merge onto the single downstream memory port

`timescale 1ns/100ps

module tlb_xlat_top #(
  parameter int unsigned NUM_ENTRIES = tlb_pkg::TLB_NUM_ENTRIES,
  parameter int unsigned VADDR_W     = tlb_pkg::TLB_VADDR_W,
  parameter int unsigned PADDR_W     = tlb_pkg::TLB_PADDR_W
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Configuration port
  input  logic                                   cfg_req_i,
  input  tlb_pkg::cfg_op_e                       cfg_op_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0]         cfg_idx_i,
  input  logic [VADDR_W-tlb_pkg::TLB_PAGE_W-1:0] cfg_vpn_i,
  input  logic [PADDR_W-tlb_pkg::TLB_PAGE_W-1:0] cfg_ppn_i,
  output logic                                   cfg_ack_o,
  // Write address channel
  input  logic                                   wr_req_i,
  input  logic [VADDR_W-1:0]                     wr_vaddr_i,
  output logic                                   wr_ack_o,
  output logic                                   wr_err_o,
  // Read address channel
  input  logic                                   rd_req_i,
  input  logic [VADDR_W-1:0]                     rd_vaddr_i,
  output logic                                   rd_ack_o,
  output logic                                   rd_err_o,
  // Downstream memory port
  output logic                                   mst_req_o,
  output logic [PADDR_W-1:0]                     mst_paddr_o,
  output logic                                   mst_we_o,
  input  logic                                   mst_ack_i
);

  import tlb_pkg::*;

  localparam int unsigned VPN_W = VADDR_W - TLB_PAGE_W;
  localparam int unsigned PPN_W = PADDR_W - TLB_PAGE_W;

  logic [VPN_W-1:0]   wr_vpn, rd_vpn;
  logic               wr_hit, rd_hit;
  logic [PPN_W-1:0]   wr_ppn, rd_ppn;
  logic               wr_xl_req, rd_xl_req;
  logic               wr_xl_ack, rd_xl_ack;
  logic [PADDR_W-1:0] wr_xl_paddr, rd_xl_paddr;

  tlb_entry_table #(
    .NUM_ENTRIES ( NUM_ENTRIES ),
    .VADDR_W     ( VADDR_W     ),
    .PADDR_W     ( PADDR_W     )
  ) u_table (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_op_i  ( cfg_op_i  ),
    .cfg_idx_i ( cfg_idx_i ),
    .cfg_vpn_i ( cfg_vpn_i ),
    .cfg_ppn_i ( cfg_ppn_i ),
    .cfg_ack_o ( cfg_ack_o ),
    .wr_vpn_i  ( wr_vpn    ),
    .wr_hit_o  ( wr_hit    ),
    .wr_ppn_o  ( wr_ppn    ),
    .rd_vpn_i  ( rd_vpn    ),
    .rd_hit_o  ( rd_hit    ),
    .rd_ppn_o  ( rd_ppn    )
  );

  tlb_lookup_chan #(
    .VADDR_W ( VADDR_W ),
    .PADDR_W ( PADDR_W )
  ) u_wr_chan (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .req_i      ( wr_req_i    ),
    .vaddr_i    ( wr_vaddr_i  ),
    .ack_o      ( wr_ack_o    ),
    .err_o      ( wr_err_o    ),
    .tbl_vpn_o  ( wr_vpn      ),
    .tbl_hit_i  ( wr_hit      ),
    .tbl_ppn_i  ( wr_ppn      ),
    .xl_req_o   ( wr_xl_req   ),
    .xl_paddr_o ( wr_xl_paddr ),
    .xl_ack_i   ( wr_xl_ack   )
  );

  tlb_lookup_chan #(
    .VADDR_W ( VADDR_W ),
    .PADDR_W ( PADDR_W )
  ) u_rd_chan (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .req_i      ( rd_req_i    ),
    .vaddr_i    ( rd_vaddr_i  ),
    .ack_o      ( rd_ack_o    ),
    .err_o      ( rd_err_o    ),
    .tbl_vpn_o  ( rd_vpn      ),
    .tbl_hit_i  ( rd_hit      ),
    .tbl_ppn_i  ( rd_ppn      ),
    .xl_req_o   ( rd_xl_req   ),
    .xl_paddr_o ( rd_xl_paddr ),
    .xl_ack_i   ( rd_xl_ack   )
  );

  tlb_xlat_merge #(
    .PADDR_W ( PADDR_W )
  ) u_merge (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .wr_req_i    ( wr_xl_req   ),
    .wr_paddr_i  ( wr_xl_paddr ),
    .wr_ack_o    ( wr_xl_ack   ),
    .rd_req_i    ( rd_xl_req   ),
    .rd_paddr_i  ( rd_xl_paddr ),
    .rd_ack_o    ( rd_xl_ack   ),
    .mst_req_o   ( mst_req_o   ),
    .mst_paddr_o ( mst_paddr_o ),
    .mst_we_o    ( mst_we_o    ),
    .mst_ack_i   ( mst_ack_i   )
  );

endmodule

// File: sim/tlb_xlat_properties.sv
// Bound protocol checker for the translation buffer top level
//  - outputs low through reset and the first cycle after it
//  - miss answers 2 cycles after the request is sampled
//  - four-phase rules on every req/ack pair
//  - downstream address stable while mst_req_o is high

`timescale 1ns/100ps

module tlb_xlat_properties #(
  parameter int unsigned PADDR_W = tlb_pkg::TLB_PADDR_W
) (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               cfg_req_i,
  input logic               cfg_ack_i,
  input logic               wr_req_i,
  input logic               wr_ack_i,
  input logic               wr_err_i,
  input logic               rd_req_i,
  input logic               rd_ack_i,
  input logic               rd_err_i,
  input logic               mst_req_i,
  input logic [PADDR_W-1:0] mst_paddr_i,
  input logic               mst_ack_i
);

  // Failure count, watched by the testbench
  int unsigned error_count;

  initial begin
    error_count = 0;
  end

  // Registered outputs come out of reset low
  reset_outputs_low: assert property (@(posedge clk_i)
    !rst_n_i |=> !cfg_ack_i && !wr_ack_i && !rd_ack_i && !mst_req_i)
  else begin
    $error("ack or mst_req_o not low around reset");
    error_count = error_count + 1;
  end

  // Miss ack 2 cycles after req is first sampled high
  wr_miss_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wr_ack_i) && wr_err_i |-> $past(wr_req_i, 2) && !$past(wr_req_i, 3))
  else begin
    $error("write miss not answered 2 cycles after the request");
    error_count = error_count + 1;
  end

  rd_miss_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(rd_ack_i) && rd_err_i |-> $past(rd_req_i, 2) && !$past(rd_req_i, 3))
  else begin
    $error("read miss not answered 2 cycles after the request");
    error_count = error_count + 1;
  end

  // An ack only rises on a request seen high
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!$rose(cfg_ack_i) || $past(cfg_req_i)) &&
    (!$rose(wr_ack_i) || $past(wr_req_i)) &&
    (!$rose(rd_ack_i) || $past(rd_req_i)) &&
    (!$rose(mst_ack_i) || mst_req_i))
  else begin
    $error("ack rose without its request");
    error_count = error_count + 1;
  end

  // Next downstream request waits for the old ack to drop
  mst_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mst_req_i) |-> $past(!mst_ack_i))
  else begin
    $error("mst_req_o rose while mst_ack_i was still high");
    error_count = error_count + 1;
  end

  mst_paddr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_i && $past(mst_req_i) |-> $stable(mst_paddr_i))
  else begin
    $error("mst_paddr_o changed during a request");
    error_count = error_count + 1;
  end

endmodule

// File: sim/tlb_xlat_tb.sv
// Testbench for the two-channel address translation buffer
//  - clock, reset and falling-edge stimulus
//  - reference model of the mapping table
//  - downstream responder with random ack delay
//  - hit, miss, invalidate, flush and contested grant checks

`timescale 1ns/100ps

module tlb_xlat_tb;

  import tlb_pkg::*;

  localparam int unsigned NUM_ENTRIES = TLB_NUM_ENTRIES;
  localparam int unsigned VADDR_W     = TLB_VADDR_W;
  localparam int unsigned PADDR_W     = TLB_PADDR_W;
  localparam int unsigned VPN_W       = VADDR_W - TLB_PAGE_W;
  localparam int unsigned PPN_W       = PADDR_W - TLB_PAGE_W;
  localparam int unsigned IDX_W       = $clog2(NUM_ENTRIES);
  // About 70 transactions of at most 30 cycles, with margin
  localparam int unsigned MAX_CYCLES  = 4000;

  logic               clk;
  logic               rst_n;
  logic               cfg_req;
  cfg_op_e            cfg_op;
  logic [IDX_W-1:0]   cfg_idx;
  logic [VPN_W-1:0]   cfg_vpn;
  logic [PPN_W-1:0]   cfg_ppn;
  logic               cfg_ack;
  logic               wr_req;
  logic [VADDR_W-1:0] wr_vaddr;
  logic               wr_ack;
  logic               wr_err;
  logic               rd_req;
  logic [VADDR_W-1:0] rd_vaddr;
  logic               rd_ack;
  logic               rd_err;
  logic               mst_req;
  logic [PADDR_W-1:0] mst_paddr;
  logic               mst_we;
  logic               mst_ack;

  // Reference copy of the table
  bit                 model_valid [NUM_ENTRIES];
  logic [VPN_W-1:0]   model_vpn [NUM_ENTRIES];
  logic [PPN_W-1:0]   model_ppn [NUM_ENTRIES];

  // Downstream requests seen, split by mst_we_o
  logic [PADDR_W-1:0] wr_seen [$];
  logic [PADDR_W-1:0] rd_seen [$];
  bit                 grants [$];
  // Round-robin pointer model, favours write after reset
  bit                 model_next_rd = 1'b0;
  int unsigned        cycle_count;

  tlb_xlat_top #(
    .NUM_ENTRIES ( NUM_ENTRIES ),
    .VADDR_W     ( VADDR_W     ),
    .PADDR_W     ( PADDR_W     )
  ) dut0 (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .cfg_req_i   ( cfg_req   ),
    .cfg_op_i    ( cfg_op    ),
    .cfg_idx_i   ( cfg_idx   ),
    .cfg_vpn_i   ( cfg_vpn   ),
    .cfg_ppn_i   ( cfg_ppn   ),
    .cfg_ack_o   ( cfg_ack   ),
    .wr_req_i    ( wr_req    ),
    .wr_vaddr_i  ( wr_vaddr  ),
    .wr_ack_o    ( wr_ack    ),
    .wr_err_o    ( wr_err    ),
    .rd_req_i    ( rd_req    ),
    .rd_vaddr_i  ( rd_vaddr  ),
    .rd_ack_o    ( rd_ack    ),
    .rd_err_o    ( rd_err    ),
    .mst_req_o   ( mst_req   ),
    .mst_paddr_o ( mst_paddr ),
    .mst_we_o    ( mst_we    ),
    .mst_ack_i   ( mst_ack   )
  );

  bind tlb_xlat_top tlb_xlat_properties #(
    .PADDR_W ( PADDR_W )
  ) u_props (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_ack_i   ( cfg_ack_o   ),
    .wr_req_i    ( wr_req_i    ),
    .wr_ack_i    ( wr_ack_o    ),
    .wr_err_i    ( wr_err_o    ),
    .rd_req_i    ( rd_req_i    ),
    .rd_ack_i    ( rd_ack_o    ),
    .rd_err_i    ( rd_err_o    ),
    .mst_req_i   ( mst_req_o   ),
    .mst_paddr_i ( mst_paddr_o ),
    .mst_ack_i   ( mst_ack_i   )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[FAIL] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic report_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "%s", msg);
  endtask

  // Lowest valid index with a matching page wins
  function automatic bit model_lookup(input logic [VADDR_W-1:0] va,
                                      output logic [PADDR_W-1:0] pa);
    bit hit;
    hit = 1'b0;
    pa  = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!hit && model_valid[i] && model_vpn[i] == va[VADDR_W-1:TLB_PAGE_W]) begin
        hit = 1'b1;
        pa  = {model_ppn[i], va[TLB_PAGE_W-1:0]};
      end
    end
    return hit;
  endfunction

  function automatic logic [VADDR_W-1:0] mapped_addr(input logic [IDX_W-1:0] idx);
    return {model_vpn[idx], TLB_PAGE_W'($urandom_range((1 << TLB_PAGE_W) - 1, 0))};
  endfunction

  // Configuration command with exact ack timing
  task automatic config_table(input cfg_op_e op, input logic [IDX_W-1:0] idx,
                              input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn);
    @(negedge clk);
    assert (cfg_ack == 1'b0) else report_mismatch("cfg_ack_o", 0, cfg_ack);
    cfg_op  = op;
    cfg_idx = idx;
    cfg_vpn = vpn;
    cfg_ppn = ppn;
    cfg_req = 1'b1;
    @(negedge clk);
    assert (cfg_ack == 1'b1) else report_mismatch("cfg_ack_o", 1, cfg_ack);
    cfg_req = 1'b0;
    @(negedge clk);
    assert (cfg_ack == 1'b0) else report_mismatch("cfg_ack_o", 0, cfg_ack);
    case (op)
      CFG_WRITE: begin
        model_valid[idx] = 1'b1;
        model_vpn[idx]   = vpn;
        model_ppn[idx]   = ppn;
      end
      CFG_INVAL: model_valid[idx] = 1'b0;
      CFG_FLUSH: begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          model_valid[i] = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  // One full four-phase translation on the write or read channel
  task automatic translate(input bit is_rd, input logic [VADDR_W-1:0] va);
    logic [PADDR_W-1:0] exp_pa;
    logic [PADDR_W-1:0] got_pa;
    bit                 exp_hit;
    int                 lat;
    logic               ack;
    logic               err;
    string              err_name;
    int                 seen;
    exp_hit = model_lookup(va, exp_pa);
    @(negedge clk);
    if (is_rd) begin
      rd_vaddr = va;
      rd_req   = 1'b1;
      err_name = "rd_err_o";
    end else begin
      wr_vaddr = va;
      wr_req   = 1'b1;
      err_name = "wr_err_o";
    end
    lat = 0;
    ack = 1'b0;
    while (!ack) begin
      @(negedge clk);
      lat++;
      ack = is_rd ? rd_ack : wr_ack;
    end
    err  = is_rd ? rd_err : wr_err;
    seen = is_rd ? rd_seen.size() : wr_seen.size();
    assert (err == !exp_hit) else report_mismatch(err_name, !exp_hit, err);
    if (!exp_hit) begin
      assert (lat == 2) else report_error("miss was not acked 2 cycles after the request");
      assert (seen == 0) else report_error("a miss sent a request downstream");
    end else begin
      assert (seen == 1)
        else report_error("a hit did not reach downstream once with the right mst_we_o");
      got_pa = is_rd ? rd_seen.pop_front() : wr_seen.pop_front();
      assert (got_pa == exp_pa) else report_mismatch("mst_paddr_o", exp_pa, got_pa);
      // The pointer moves away from the side just served
      model_next_rd = !is_rd;
    end
    if (is_rd) begin
      rd_req = 1'b0;
    end else begin
      wr_req = 1'b0;
    end
    while (is_rd ? rd_ack : wr_ack) @(negedge clk);
  endtask

  // Two hits at once, then one more on the winner so the next pair flips
  task automatic contested_pair(input logic [IDX_W-1:0] wi, input logic [IDX_W-1:0] ri);
    logic [VADDR_W-1:0] wa;
    logic [VADDR_W-1:0] ra;
    bit                 exp_first_rd;
    wa = mapped_addr(wi);
    ra = mapped_addr(ri);
    exp_first_rd = model_next_rd;
    grants.delete();
    fork
      translate(1'b0, wa);
      translate(1'b1, ra);
    join
    assert (grants.size() == 2)
      else report_error("both channels were not served one after the other");
    assert (grants[0] == exp_first_rd)
      else report_mismatch("mst_we_o", !exp_first_rd, !grants[0]);
    // Loser went last, so the pointer now favours the winner
    model_next_rd = exp_first_rd;
    translate(exp_first_rd, mapped_addr(exp_first_rd ? ri : wi));
  endtask

  // Downstream memory port following the four-phase rule
  initial begin : downstream
    int delay;
    forever begin
      @(negedge clk);
      if (rst_n && mst_req && !mst_ack) begin
        if (mst_we) begin
          wr_seen.push_back(mst_paddr);
        end else begin
          rd_seen.push_back(mst_paddr);
        end
        grants.push_back(!mst_we);
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        mst_ack = 1'b1;
        @(negedge clk);
        while (mst_req) @(negedge clk);
        mst_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  initial begin : property_watch
    wait (dut0.u_props.error_count != 0);
    $display("[FAIL] %0t ns: a protocol assertion in the bound checker failed", $time);
    $display("Simulation FAILED");
    $fatal(1, "protocol assertion failed");
  end

  initial begin
    void'($urandom(32'hfcdd_92ab));
    rst_n    = 1'b0;
    cfg_req  = 1'b0;
    cfg_op   = CFG_NOP;
    cfg_idx  = '0;
    cfg_vpn  = '0;
    cfg_ppn  = '0;
    wr_req   = 1'b0;
    wr_vaddr = '0;
    rd_req   = 1'b0;
    rd_vaddr = '0;
    mst_ack  = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      config_table(CFG_WRITE, IDX_W'(i), VPN_W'($urandom()), PPN_W'($urandom()));
    end
    // Duplicate page in a higher index stays hidden behind index 2
    config_table(CFG_WRITE, 5, model_vpn[2], PPN_W'($urandom()));
    translate(1'b0, mapped_addr(2));
    translate(1'b1, mapped_addr(2));
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      translate(i[0], mapped_addr(IDX_W'(i)));
    end

    // Unmapped addresses
    for (int i = 0; i < 4; i++) begin
      translate(1'($urandom_range(1, 0)), VADDR_W'($urandom()));
    end
    config_table(CFG_NOP, 0, '0, '0);
    config_table(CFG_INVAL, 3, '0, '0);
    translate(1'b0, mapped_addr(3));
    translate(1'b1, mapped_addr(3));

    // New ppn on an existing index
    config_table(CFG_WRITE, 1, model_vpn[1], PPN_W'($urandom()));
    translate(1'b0, mapped_addr(1));
    translate(1'b1, mapped_addr(1));
    config_table(CFG_WRITE, 3, model_vpn[3], PPN_W'($urandom()));

    for (int n = 0; n < 10; n++) begin
      contested_pair(IDX_W'($urandom_range(NUM_ENTRIES - 1, 0)),
                     IDX_W'($urandom_range(NUM_ENTRIES - 1, 0)));
    end

    config_table(CFG_FLUSH, 0, '0, '0);
    for (int i = 0; i < 4; i++) begin
      translate(i[0], mapped_addr(IDX_W'($urandom_range(NUM_ENTRIES - 1, 0))));
    end

    repeat (2) @(negedge clk);
    // Misses must never have reached the downstream port
    assert (wr_seen.size() == 0 && rd_seen.size() == 0)
      else report_error("a downstream request appeared without a matching hit");
    if (dut0.u_props.error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tlb_xlat_top.f
src/tlb_pkg.sv
src/tlb_entry_table.sv
src/tlb_lookup_chan.sv
src/tlb_xlat_merge.sv
src/tlb_xlat_top.sv
sim/tlb_xlat_properties.sv
sim/tlb_xlat_tb.sv

// File: Bender.yml
package:
  name: tlb_xlat

sources:
  - src/tlb_pkg.sv
  - src/tlb_entry_table.sv
  - src/tlb_lookup_chan.sv
  - src/tlb_xlat_merge.sv
  - src/tlb_xlat_top.sv
  - target: simulation
    files:
      - sim/tlb_xlat_properties.sv
      - sim/tlb_xlat_tb.sv
